// File: hdl/mont_pkg.sv
`default_nettype none

package mont_pkg;

    // operand and datapath widths
    localparam int N_BITS     = 128;
    localparam int MULT_BITS  = N_BITS + 2;     // room for 3x
    localparam int ACC_BITS   = N_BITS + 4;     // headroom plus sign for the final subtract
    localparam int ITERATIONS = N_BITS / 2;     // radix-4 digits of A
    localparam int ITER_BITS  = $clog2(ITERATIONS);

    // adder chunking, one chunk per cycle
    localparam int ADD_CHUNK    = 44;
    localparam int ADD_CYCLES   = (ACC_BITS + ADD_CHUNK - 1) / ADD_CHUNK;
    localparam int ADD_BITS     = ADD_CYCLES * ADD_CHUNK;   // padded to whole chunks
    localparam int ADD_CNT_BITS = $clog2(ADD_CYCLES + 1);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PREP,
        ST_ADD_B,
        ST_ADD_M,
        ST_SHIFT,
        ST_SUB,
        ST_DONE
    } ctrl_state_t;

    // what digit_select puts on the adder
    typedef enum logic [1:0] {
        SEL_B_DIGIT,    // digit of A times B
        SEL_M_QUOT,     // q times M, clears the two low bits of C
        SEL_M_ONE       // plain M for the final subtract
    } addend_sel_t;

endpackage

`default_nettype wire

// File: hdl/multiple_gen.sv
`timescale 1ns/1ns
`default_nettype none

module multiple_gen (
    input  logic                           clk,
    input  logic                           resetn,
    input  logic                           load,
    input  logic [mont_pkg::N_BITS-1:0]    operand,
    output logic [mont_pkg::MULT_BITS-1:0] x1,
    output logic [mont_pkg::MULT_BITS-1:0] x2,
    output logic [mont_pkg::MULT_BITS-1:0] x3
);

    import mont_pkg::*;

    logic load_d;   // second build cycle

    always_ff @(posedge clk) begin
        if (!resetn) begin
            load_d <= 1'b0;
        end else begin
            load_d <= load;
        end
    end

    // 1x and 2x straight from the operand
    always_ff @(posedge clk) begin
        if (load) begin
            x1 <= MULT_BITS'(operand);
            x2 <= MULT_BITS'({operand, 1'b0});
        end
    end

    // 3x needs the registered copies, so one cycle later
    always_ff @(posedge clk) begin
        if (load_d) begin
            x3 <= x1 + x2;
        end
    end

endmodule

`default_nettype wire

// File: hdl/digit_select.sv
`timescale 1ns/1ns
`default_nettype none

module digit_select (
    input  mont_pkg::addend_sel_t          sel,
    input  logic [1:0]                     a_digit,
    input  logic [1:0]                     acc_low,
    input  logic [mont_pkg::MULT_BITS-1:0] b1,
    input  logic [mont_pkg::MULT_BITS-1:0] b2,
    input  logic [mont_pkg::MULT_BITS-1:0] b3,
    input  logic [mont_pkg::MULT_BITS-1:0] m1,
    input  logic [mont_pkg::MULT_BITS-1:0] m2,
    input  logic [mont_pkg::MULT_BITS-1:0] m3,
    output logic [mont_pkg::MULT_BITS-1:0] addend
);

    import mont_pkg::*;

    logic [1:0] q;

    // 0, 1x, 2x or 3x by a two bit digit
    function automatic logic [MULT_BITS-1:0] pick(
        input logic [1:0]           digit,
        input logic [MULT_BITS-1:0] v1,
        input logic [MULT_BITS-1:0] v2,
        input logic [MULT_BITS-1:0] v3
    );
        case (digit)
            2'd1:    pick = v1;
            2'd2:    pick = v2;
            2'd3:    pick = v3;
            default: pick = '0;
        endcase
    endfunction

    // q = -C * M^-1 mod 4, and M is its own inverse mod 4 since M is odd
    assign q = 2'd0 - acc_low * m1[1:0];

    always_comb begin
        case (sel)
            SEL_B_DIGIT: addend = pick(a_digit, b1, b2, b3);
            SEL_M_QUOT:  addend = pick(q, m1, m2, m3);
            default:     addend = m1;   // subtract phase
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/wide_adder.sv
`timescale 1ns/1ns
`default_nettype none

module wide_adder (
    input  logic                           clk,
    input  logic                           resetn,
    input  logic                           start,
    input  logic                           subtract,
    input  logic [mont_pkg::ACC_BITS-1:0]  op_a,
    input  logic [mont_pkg::MULT_BITS-1:0] op_b,
    output logic [mont_pkg::ACC_BITS-1:0]  sum,
    output logic                           done
);

    import mont_pkg::*;

    logic [ADD_BITS-1:0]     a_q;       // operands shift down one chunk per cycle
    logic [ADD_BITS-1:0]     b_q;
    logic [ADD_BITS-1:0]     s_q;       // result fills in from the top
    logic                    carry_q;
    logic [ADD_CNT_BITS-1:0] cnt;       // chunks written so far
    logic                    busy;
    logic [ADD_BITS-1:0]     a_src;
    logic [ADD_BITS-1:0]     b_src;
    logic                    c_src;
    logic [ADD_CHUNK-1:0]    chunk_sum;
    logic                    chunk_cout;

    // first chunk comes straight from the inputs on the start cycle
    assign a_src = start ? ADD_BITS'(op_a) : a_q;
    assign b_src = start ? (subtract ? ~ADD_BITS'(op_b) : ADD_BITS'(op_b)) : b_q;
    assign c_src = start ? subtract : carry_q;   // +1 completes the two's complement

    assign {chunk_cout, chunk_sum} = a_src[ADD_CHUNK-1:0] + b_src[ADD_CHUNK-1:0] + c_src;

    always_ff @(posedge clk) begin
        if (start || busy) begin
            a_q     <= a_src >> ADD_CHUNK;
            b_q     <= b_src >> ADD_CHUNK;
            s_q     <= {chunk_sum, s_q[ADD_BITS-1:ADD_CHUNK]};
            carry_q <= chunk_cout;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else if (start) begin
            busy <= (ADD_CYCLES > 1);
            cnt  <= ADD_CNT_BITS'(1);
            done <= (ADD_CYCLES == 1);
        end else if (busy) begin
            cnt <= cnt + 1'b1;
            if (cnt == ADD_CNT_BITS'(ADD_CYCLES - 1)) begin
                busy <= 1'b0;   // last chunk goes in now
                done <= 1'b1;
            end
        end else begin
            done <= 1'b0;
        end
    end

    assign sum = s_q[ACC_BITS-1:0];

endmodule

`default_nettype wire

// File: hdl/mont_accum.sv
`timescale 1ns/1ns
`default_nettype none

module mont_accum (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          load,
    input  logic [mont_pkg::N_BITS-1:0]   in_a,
    input  logic [mont_pkg::ACC_BITS-1:0] sum,
    input  logic                          acc_write,
    input  logic                          acc_shift,
    input  logic                          result_write,
    output logic [1:0]                    a_digit,
    output logic [mont_pkg::ACC_BITS-1:0] acc,
    output logic [mont_pkg::N_BITS-1:0]   result
);

    import mont_pkg::*;

    logic [N_BITS-1:0]   a_reg;
    logic [ACC_BITS-1:0] c_reg;
    logic [N_BITS-1:0]   res_reg;

    // A walks down two bits per iteration, LSB digit first
    always_ff @(posedge clk) begin
        if (load) begin
            a_reg <= in_a;
        end else if (acc_shift) begin
            a_reg <= a_reg >> 2;
        end
    end

    // accumulator C
    always_ff @(posedge clk) begin
        if (!resetn) begin
            c_reg <= '0;
        end else if (load) begin
            c_reg <= '0;
        end else if (acc_write) begin
            c_reg <= sum;
        end else if (acc_shift) begin
            // low two bits are zero after the q*M add, so this is an exact divide by 4
            c_reg <= c_reg >> 2;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            res_reg <= '0;
        end else if (result_write) begin
            res_reg <= c_reg[N_BITS-1:0];   // C < M here
        end
    end

    assign a_digit = a_reg[1:0];
    assign acc     = c_reg;
    assign result  = res_reg;

endmodule

`default_nettype wire

// File: hdl/mont_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module mont_ctrl (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  start,
    input  logic                  add_done,
    input  logic                  sum_sign,
    output logic                  load,
    output logic                  add_start,
    output logic                  subtract,
    output logic                  acc_write,
    output logic                  acc_shift,
    output logic                  result_write,
    output logic                  done,
    output mont_pkg::addend_sel_t sel
);

    import mont_pkg::*;

    ctrl_state_t          state;
    ctrl_state_t          next_state;
    logic [ITER_BITS-1:0] iter;         // iterations finished
    logic                 add_busy;     // adder running for this state
    logic                 in_add;
    logic                 last_iter;

    assign in_add    = (state == ST_ADD_B) || (state == ST_ADD_M) || (state == ST_SUB);
    assign last_iter = (iter == ITER_BITS'(ITERATIONS - 1));

    // strobes decoded from the state
    assign load         = (state == ST_IDLE) && start;   // busy starts are dropped
    assign add_start    = in_add && !add_busy;
    assign subtract     = (state == ST_SUB);
    assign acc_shift    = (state == ST_SHIFT);
    assign done         = (state == ST_DONE);
    assign result_write = (state == ST_SUB) && add_done && sum_sign;

    always_comb begin
        acc_write = 1'b0;
        if (add_done) begin
            // keep the trial difference only while it stays non-negative
            acc_write = (state == ST_SUB) ? !sum_sign : in_add;
        end
    end

    always_comb begin
        case (state)
            ST_ADD_B: sel = SEL_B_DIGIT;
            ST_ADD_M: sel = SEL_M_QUOT;
            default:  sel = SEL_M_ONE;
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE:  if (start) next_state = ST_PREP;
            ST_PREP:  next_state = ST_ADD_B;        // 3x lands at the end of this cycle
            ST_ADD_B: if (add_done) next_state = ST_ADD_M;
            ST_ADD_M: if (add_done) next_state = ST_SHIFT;
            ST_SHIFT: next_state = last_iter ? ST_SUB : ST_ADD_B;
            ST_SUB:   if (add_done && sum_sign) next_state = ST_DONE;
            ST_DONE:  next_state = ST_IDLE;
            default:  next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            iter <= '0;
        end else if (load) begin
            iter <= '0;
        end else if (acc_shift) begin
            iter <= iter + 1'b1;
        end
    end

    // one adder run per add state, one per trial in ST_SUB
    always_ff @(posedge clk) begin
        if (!resetn) begin
            add_busy <= 1'b0;
        end else if (add_start) begin
            add_busy <= 1'b1;
        end else if (add_done) begin
            add_busy <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: hdl/montgomery.sv
`timescale 1ns/1ns
`default_nettype none

module montgomery (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        start,
    input  logic [mont_pkg::N_BITS-1:0] in_a,
    input  logic [mont_pkg::N_BITS-1:0] in_b,
    input  logic [mont_pkg::N_BITS-1:0] in_m,
    output logic [mont_pkg::N_BITS-1:0] result,
    output logic                        done
);

    import mont_pkg::*;

    logic                 load;
    logic                 add_start;
    logic                 subtract;
    logic                 acc_write;
    logic                 acc_shift;
    logic                 result_write;
    logic                 add_done;
    addend_sel_t          sel;
    logic [MULT_BITS-1:0] b1, b2, b3;
    logic [MULT_BITS-1:0] m1, m2, m3;
    logic [MULT_BITS-1:0] addend;
    logic [ACC_BITS-1:0]  sum;
    logic [ACC_BITS-1:0]  acc;
    logic [1:0]           a_digit;

    mont_ctrl i_ctrl (
        .clk(clk), .resetn(resetn), .start(start),
        .add_done(add_done), .sum_sign(sum[ACC_BITS-1]),
        .load(load), .add_start(add_start), .subtract(subtract),
        .acc_write(acc_write), .acc_shift(acc_shift),
        .result_write(result_write), .done(done), .sel(sel)
    );

    multiple_gen gen_b (
        .clk(clk), .resetn(resetn), .load(load), .operand(in_b),
        .x1(b1), .x2(b2), .x3(b3)
    );

    multiple_gen gen_m (
        .clk(clk), .resetn(resetn), .load(load), .operand(in_m),
        .x1(m1), .x2(m2), .x3(m3)
    );

    digit_select i_select (
        .sel(sel), .a_digit(a_digit), .acc_low(acc[1:0]),
        .b1(b1), .b2(b2), .b3(b3), .m1(m1), .m2(m2), .m3(m3),
        .addend(addend)
    );

    wide_adder i_adder (
        .clk(clk), .resetn(resetn), .start(add_start), .subtract(subtract),
        .op_a(acc), .op_b(addend), .sum(sum), .done(add_done)
    );

    mont_accum i_accum (
        .clk(clk), .resetn(resetn), .load(load), .in_a(in_a), .sum(sum),
        .acc_write(acc_write), .acc_shift(acc_shift),
        .result_write(result_write), .a_digit(a_digit), .acc(acc),
        .result(result)
    );

endmodule

`default_nettype wire

// File: bench/tb_montgomery.sv
`timescale 1ns/1ns
`default_nettype none

module tb_montgomery;

    import mont_pkg::*;

    localparam int          CLK_PERIOD     = 8;
    localparam int          DRIVE_DELAY    = 1;     // ns after the rising edge
    localparam int          RESET_CYCLES   = 3;
    localparam int          NUM_PATTERNS   = 14;
    localparam int          PATTERN_WORDS  = 4;     // in_a, in_b, in_m, expected
    localparam logic [31:0] LFSR_SEED      = 32'h32e5;
    localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;
    localparam int          GAP_BITS       = 3;
    localparam int          GAP_MAX        = (1 << GAP_BITS) - 1;
    localparam int          IDLE_CHECK     = 20;
    localparam int          BUSY_START_AT  = 10;    // cycles into a run
    localparam int          PREP_CYCLES    = 2;
    localparam int          SUB_CYCLES     = 3 * (ADD_CYCLES + 2) + 1;
    localparam int          RUN_CYCLES     = ITERATIONS * (2 * (ADD_CYCLES + 2) + 1)
                                             + PREP_CYCLES + SUB_CYCLES;
    localparam int          TIMEOUT_MARGIN = 100;
    localparam int          TIMEOUT_CYCLES = RESET_CYCLES + IDLE_CHECK
                                             + (NUM_PATTERNS + 2) * (RUN_CYCLES + GAP_MAX + 4)
                                             + TIMEOUT_MARGIN;

    logic              clk;
    logic              resetn;
    logic              start;
    logic [N_BITS-1:0] in_a;
    logic [N_BITS-1:0] in_b;
    logic [N_BITS-1:0] in_m;
    logic [N_BITS-1:0] result;
    logic              done;

    logic [N_BITS-1:0] pattern_mem [0:NUM_PATTERNS*PATTERN_WORDS-1];
    logic [31:0]       lfsr;
    int                cycle_count = 0;

    montgomery i_montgomery (
        .clk(clk), .resetn(resetn), .start(start),
        .in_a(in_a), .in_b(in_b), .in_m(in_m),
        .result(result), .done(done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // hard limit on the whole run
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_failure("timeout, the run took longer than the worst case allows");
        end
    end

    function automatic logic [31:0] galois_step(input logic [31:0] s);
        galois_step = s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // one LFSR step per bit taken
    task automatic random_bits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr  = galois_step(lfsr);
        end
    endtask

    function automatic logic [N_BITS-1:0] pattern_word(input int idx, input int word);
        pattern_word = pattern_mem[idx * PATTERN_WORDS + word];
    endfunction

    task automatic check_result(input string name, input logic [N_BITS-1:0] expected,
                                input logic [N_BITS-1:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("Error: %s: expected %h, actual %h",
                                     name, expected, actual));
        end
    endtask

    task automatic check_done(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            report_failure($sformatf("Error: %s: expected done %b, actual %b",
                                     name, expected, actual));
        end
    endtask

    task automatic step_clock();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // no done may show up while nothing runs
    task automatic quiet_cycles(input string name, input int count);
        repeat (count) begin
            step_clock();
            check_done(name, 1'b0, done);
        end
    endtask

    task automatic start_run(input int idx);
        in_a  = pattern_word(idx, 0);
        in_b  = pattern_word(idx, 1);
        in_m  = pattern_word(idx, 2);
        start = 1'b1;
        step_clock();
        start = 1'b0;
        in_a  = ~in_a;      // operands are already captured
        in_b  = ~in_b;
        in_m  = ~in_m;
    endtask

    task automatic wait_for_done(input string name);
        int waited;
        waited = 0;
        while (done !== 1'b1) begin
            if (waited >= RUN_CYCLES) begin
                report_failure($sformatf("%s: done never came within %0d cycles",
                                         name, RUN_CYCLES));
            end
            step_clock();
            waited++;
        end
    endtask

    task automatic run_pattern(input int idx, input int gap);
        string name;
        name = $sformatf("pattern %0d", idx);
        quiet_cycles(name, gap);
        start_run(idx);
        wait_for_done(name);
        check_result(name, pattern_word(idx, 3), result);
        step_clock();
        check_done({name, " strobe length"}, 1'b0, done);   // one cycle only
    endtask

    // a start during a busy run must be dropped
    task automatic busy_start_run();
        string name;
        name = "busy start";
        start_run(0);
        quiet_cycles(name, BUSY_START_AT);
        in_a  = pattern_word(1, 0);
        in_b  = pattern_word(1, 1);
        in_m  = pattern_word(1, 2);
        start = 1'b1;
        step_clock();
        start = 1'b0;
        wait_for_done(name);
        check_result(name, pattern_word(0, 3), result);
        quiet_cycles({name, " no second run"}, RUN_CYCLES);
    endtask

    initial begin
        int gap;
        clk    = 1'b0;
        resetn = 1'b0;
        start  = 1'b0;
        in_a   = '0;
        in_b   = '0;
        in_m   = '0;
        lfsr   = LFSR_SEED;

        $readmemh("bench/montgomery_patterns.txt", pattern_mem);
        if ($isunknown(pattern_mem[NUM_PATTERNS*PATTERN_WORDS-1])) begin
            report_failure("pattern file is missing or holds fewer patterns than expected");
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        resetn = 1'b1;

        quiet_cycles("idle after reset", IDLE_CHECK);

        for (int idx = 0; idx < NUM_PATTERNS; idx++) begin
            random_bits(GAP_BITS, gap);
            run_pattern(idx, gap);
        end

        busy_start_run();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/montgomery_patterns.txt
// each line holds in_a in_b in_m and the expected result in hex
// expected result is in_a * in_b * 2^-128 mod in_m
10000000000000000 0123456789abcdeffedcba9876543210 ffffffffffffffffffffffffffffffff fedcba98765432100123456789abcdef
3 5 ffffffffffffffffffffffffffffffff f
0 0123456789abcdeffedcba9876543210 ffffffffffffffffffffffffffffffff 0
0123456789abcdeffedcba9876543210 1 ffffffffffffffffffffffffffffffff 0123456789abcdeffedcba9876543210
fffffffffffffffffffffffffffffffe fffffffffffffffffffffffffffffffe ffffffffffffffffffffffffffffffff 1
2 2 3 1
1 2 3 2
7fffffffffffffffffffffffffffffff 0123456789abcdeffedcba9876543210 80000000000000000000000000000001 0123456789abcdeffedcba9876543210
4 8 80000000000000000000000000000001 7ffffffffffffffffffffffffffffff1
80000000000000000000000000000000 80000000000000000000000000000000 80000000000000000000000000000001 40000000000000000000000000000000
10 f0000000000000000000000000000001 ffffffffffffffffffffffffffffffff 1f
7fffffffffffffffffffffffffffffff 1 80000000000000000000000000000001 1
2 1 3 2
40000000000000000000000000000000 2 80000000000000000000000000000001 40000000000000000000000000000001

// File: vlog.f
hdl/mont_pkg.sv
hdl/multiple_gen.sv
hdl/digit_select.sv
hdl/wide_adder.sv
hdl/mont_accum.sv
hdl/mont_ctrl.sv
hdl/montgomery.sv
bench/tb_montgomery.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_montgomery
FILELIST   := vlog.f
MDIR       := obj_dir
LOG        := sim.log
PASS_MSG   := TESTBENCH PASSED
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -Wno-fatal --Mdir $(MDIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(MDIR)/V$(TOP): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -o V$(TOP)

sim: $(MDIR)/V$(TOP)
	-./$(MDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(MDIR) $(LOG)
